// ==== build.f ====
+incdir+testbench
rtl/csr_addr_pkg.sv
rtl/csr_field_pkg.sv
rtl/csr_trap_if.sv
rtl/csr_regfile.sv
rtl/csr_trap_ctrl.sv
rtl/csr_timer.sv
rtl/csr_top.sv
testbench/csr_tb.sv

// ==== testbench/csr_tb_util.svh ====
`ifndef CSR_TB_UTIL_SVH
`define CSR_TB_UTIL_SVH

int check_count = 0;
int err_count   = 0;

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd54533;

function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
endfunction

// one lfsr step per bit
function automatic csr_word_t lfsr_word();
    csr_word_t word;
    word = '0;
    for (int i = 0; i < CSR_DATA_W; i++) begin
        word[i] = lfsr_bit();
    end
    return word;
endfunction

task automatic check_word(input string test, input csr_word_t exp, input csr_word_t act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %s expected %h actual %h", test, exp, act);
    end
endtask

task automatic check_plv(input string test, input plv_t exp, input plv_t act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %s expected plv %0d actual plv %0d", test, exp, act);
    end
endtask

task automatic check_bit(input string test, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("ERR %s expected %b actual %b", test, exp, act);
    end
endtask

task automatic report_test(input string test, input int errs_before);
    $display("%s: done, %0d error(s)", test, err_count - errs_before);
endtask

`endif

// ==== testbench/csr_tb.sv ====
`timescale 1ns/10ps

module csr_tb;
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  wr1_we;
    csr_addr_e             wr1_addr;
    csr_word_t             wr1_data;
    logic                  wr2_we;
    csr_addr_e             wr2_addr;
    csr_word_t             wr2_data;
    logic [CSR_ADDR_W-1:0] raddr1;
    logic [CSR_ADDR_W-1:0] raddr2;
    csr_word_t             rdata1;
    csr_word_t             rdata2;
    logic                  excp_flush;
    logic                  ertn_flush;
    ecode_t                ecode;
    esubcode_t             esubcode;
    csr_word_t             era;
    hw_irq_t               irq;
    logic                  has_int;
    plv_t                  plv;
    csr_word_t             eentry;
    csr_word_t             era_out;

    `include "csr_tb_util.svh"

    csr_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .wr1_we_i     (wr1_we),
        .wr1_addr_i   (wr1_addr),
        .wr1_data_i   (wr1_data),
        .wr2_we_i     (wr2_we),
        .wr2_addr_i   (wr2_addr),
        .wr2_data_i   (wr2_data),
        .raddr1_i     (raddr1),
        .raddr2_i     (raddr2),
        .rdata1_o     (rdata1),
        .rdata2_o     (rdata2),
        .excp_flush_i (excp_flush),
        .ertn_flush_i (ertn_flush),
        .ecode_i      (ecode),
        .esubcode_i   (esubcode),
        .era_i        (era),
        .irq_i        (irq),
        .has_int_o    (has_int),
        .plv_o        (plv),
        .eentry_o     (eentry),
        .era_o        (era_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // every drive happens 1 ns after a rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input int port, input csr_addr_e addr, input csr_word_t data);
        if (port == 1) begin
            wr1_we   = 1'b1;
            wr1_addr = addr;
            wr1_data = data;
        end else begin
            wr2_we   = 1'b1;
            wr2_addr = addr;
            wr2_data = data;
        end
        step();
        wr1_we = 1'b0;
        wr2_we = 1'b0;
    endtask

    // read data is combinational, sampled mid cycle
    task automatic check_read(input string test, input logic [CSR_ADDR_W-1:0] addr,
                              input csr_word_t exp);
        raddr1 = addr;
        raddr2 = addr;
        #1;
        check_word(test, exp, rdata1);
        check_word(test, exp, rdata2);
        step();
    endtask

    task automatic wait_has_int(input string test, input logic exp, input int limit);
        int n;
        n = 0;
        while (has_int !== exp && n < limit) begin
            step();
            n++;
        end
        check_count++;
        if (has_int !== exp) begin
            err_count++;
            $display("%s: has_int_o did not go %s within %0d cycles", test,
                     exp ? "high" : "low", limit);
        end
    endtask

    task automatic reset_values();
        int errs;
        errs = err_count;
        check_read("reset", CSR_CRMD, 32'h0000_0008);
        check_read("reset", CSR_PRMD, '0);
        check_read("reset", CSR_ESTAT, '0);
        check_read("reset", CSR_TCFG, '0);
        check_read("reset", CSR_TVAL, '0);
        check_bit("reset", 1'b0, has_int);
        check_plv("reset", '0, plv);
        report_test("reset", errs);
    endtask

    task automatic storage_regs();
        int        errs;
        csr_addr_e regs [6];
        csr_word_t data [6];
        csr_word_t exp;
        errs = err_count;
        regs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_EENTRY};
        for (int i = 0; i < 6; i++) begin
            data[i] = lfsr_word();
            write_csr((i % 2) + 1, regs[i], data[i]);
        end
        for (int i = 0; i < 6; i++) begin
            exp = data[i];
            if (regs[i] == CSR_EENTRY) begin
                exp[EENTRY_VA_LO-1:0] = '0;
            end
            check_read("storage", regs[i], exp);
        end
        check_word("storage", data[5] & ~32'h3f, eentry);
        check_read("storage", 14'h3ff, '0);
        check_read("storage", CSR_TICLR, '0);
        report_test("storage", errs);
    endtask

    task automatic trap_entry_return();
        int        errs;
        csr_word_t crmd_exp;
        csr_word_t prmd_exp;
        csr_word_t estat_exp;
        csr_word_t era_val;
        errs = err_count;
        crmd_exp = CRMD_RESET;
        crmd_exp[CRMD_PLV_HI:CRMD_PLV_LO] = 2'd3;
        crmd_exp[CRMD_IE] = 1'b1;
        write_csr(1, CSR_CRMD, crmd_exp);
        check_plv("trap", 2'd3, plv);

        era_val = lfsr_word();
        excp_flush = 1'b1;
        ecode      = 6'h0b;
        esubcode   = 9'h0a5;
        era        = era_val;
        step();
        excp_flush = 1'b0;

        prmd_exp = '0;
        prmd_exp[PRMD_PPLV_HI:PRMD_PPLV_LO] = 2'd3;
        prmd_exp[PRMD_PIE] = 1'b1;
        estat_exp = '0;
        estat_exp[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = 6'h0b;
        estat_exp[ESTAT_ESUB_HI:ESTAT_ESUB_LO] = 9'h0a5;
        check_plv("trap", '0, plv);
        check_word("trap", era_val, era_out);
        check_read("trap", CSR_PRMD, prmd_exp);
        check_read("trap", CSR_CRMD, CRMD_RESET);
        check_read("trap", CSR_ESTAT, estat_exp);
        check_read("trap", CSR_ERA, era_val);

        ertn_flush = 1'b1;
        step();
        ertn_flush = 1'b0;
        check_plv("trap", 2'd3, plv);
        check_read("trap", CSR_CRMD, crmd_exp);
        write_csr(2, CSR_CRMD, CRMD_RESET);
        report_test("trap", errs);
    endtask

    task automatic interrupt_enable();
        int        errs;
        csr_word_t lie;
        csr_word_t crmd_ie;
        csr_word_t estat_exp;
        errs = err_count;
        crmd_ie = CRMD_RESET;
        crmd_ie[CRMD_IE] = 1'b1;
        // hardware line 3 lands in IS bit 5
        lie = '0;
        lie[ESTAT_HWI_LO + 3] = 1'b1;
        irq = 8'h08;
        write_csr(1, CSR_ECTL, lie);
        write_csr(2, CSR_CRMD, crmd_ie);
        wait_has_int("interrupt", 1'b1, 10);
        write_csr(1, CSR_CRMD, CRMD_RESET);
        check_bit("interrupt", 1'b0, has_int);
        write_csr(2, CSR_CRMD, crmd_ie);
        wait_has_int("interrupt", 1'b1, 10);
        write_csr(1, CSR_ECTL, '0);
        check_bit("interrupt", 1'b0, has_int);
        irq = '0;

        // software interrupt 0
        lie = '0;
        lie[ESTAT_SWI_LO] = 1'b1;
        write_csr(2, CSR_ECTL, lie);
        write_csr(1, CSR_ESTAT, 32'h1);
        wait_has_int("interrupt", 1'b1, 10);
        // codes still held from the trap test
        estat_exp = '0;
        estat_exp[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = 6'h0b;
        estat_exp[ESTAT_ESUB_HI:ESTAT_ESUB_LO] = 9'h0a5;
        estat_exp[ESTAT_SWI_LO] = 1'b1;
        check_read("interrupt", CSR_ESTAT, estat_exp);
        write_csr(2, CSR_ESTAT, '0);
        check_bit("interrupt", 1'b0, has_int);
        write_csr(1, CSR_ECTL, '0);
        write_csr(2, CSR_CRMD, CRMD_RESET);
        report_test("interrupt", errs);
    endtask

    task automatic timer_modes();
        int        errs;
        csr_word_t lie;
        csr_word_t crmd_ie;
        csr_word_t cfg;
        csr_word_t load;
        errs = err_count;
        crmd_ie = CRMD_RESET;
        crmd_ie[CRMD_IE] = 1'b1;
        lie = '0;
        lie[ESTAT_TI] = 1'b1;
        write_csr(1, CSR_ECTL, lie);
        write_csr(2, CSR_CRMD, crmd_ie);

        // one shot
        cfg = 32'd4 << TCFG_INITVAL_LO;
        cfg[TCFG_EN] = 1'b1;
        load = {cfg[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b00};
        write_csr(1, CSR_TCFG, cfg);
        step();
        raddr1 = CSR_TVAL;
        #1;
        check_bit("timer", 1'b1, rdata1 < load);
        step();
        wait_has_int("timer", 1'b1, 40);
        cfg[TCFG_EN] = 1'b0;
        check_read("timer", CSR_TCFG, cfg);
        write_csr(2, CSR_TICLR, 32'h1);
        check_bit("timer", 1'b0, has_int);

        // periodic
        cfg = 32'd2 << TCFG_INITVAL_LO;
        cfg[TCFG_EN] = 1'b1;
        cfg[TCFG_PERIODIC] = 1'b1;
        write_csr(1, CSR_TCFG, cfg);
        for (int i = 0; i < 3; i++) begin
            wait_has_int("timer", 1'b1, 30);
            write_csr(2, CSR_TICLR, 32'h1);
            check_bit("timer", 1'b0, has_int);
        end
        write_csr(1, CSR_TCFG, '0);
        write_csr(2, CSR_TICLR, 32'h1);
        write_csr(1, CSR_ECTL, '0);
        write_csr(2, CSR_CRMD, CRMD_RESET);
        report_test("timer", errs);
    endtask

    initial begin
        rst        = 1'b1;
        wr1_we     = 1'b0;
        wr1_addr   = CSR_CRMD;
        wr1_data   = '0;
        wr2_we     = 1'b0;
        wr2_addr   = CSR_CRMD;
        wr2_data   = '0;
        raddr1     = '0;
        raddr2     = '0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        ecode      = '0;
        esubcode   = '0;
        era        = '0;
        irq        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_values();
        storage_regs();
        trap_entry_return();
        interrupt_enable();
        timer_modes();

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/csr_top.sv ====
`timescale 1ns/10ps

module csr_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr1_we_i,
    input  csr_addr_pkg::csr_addr_e             wr1_addr_i,
    input  csr_addr_pkg::csr_word_t             wr1_data_i,
    input  logic                                wr2_we_i,
    input  csr_addr_pkg::csr_addr_e             wr2_addr_i,
    input  csr_addr_pkg::csr_word_t             wr2_data_i,
    input  logic [csr_addr_pkg::CSR_ADDR_W-1:0] raddr1_i,
    input  logic [csr_addr_pkg::CSR_ADDR_W-1:0] raddr2_i,
    output csr_addr_pkg::csr_word_t             rdata1_o,
    output csr_addr_pkg::csr_word_t             rdata2_o,
    input  logic                                excp_flush_i,
    input  logic                                ertn_flush_i,
    input  csr_field_pkg::ecode_t               ecode_i,
    input  csr_field_pkg::esubcode_t            esubcode_i,
    input  csr_addr_pkg::csr_word_t             era_i,
    input  csr_field_pkg::hw_irq_t              irq_i,
    output logic                                has_int_o,
    output csr_field_pkg::plv_t                 plv_o,
    output csr_addr_pkg::csr_word_t             eentry_o,
    output csr_addr_pkg::csr_word_t             era_o
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic      wr_we;
    csr_addr_e wr_addr;
    csr_word_t wr_data;
    int_vec_t  ectl_lie;
    csr_word_t crmd;
    csr_word_t prmd;
    csr_word_t estat;
    csr_word_t tcfg;
    csr_word_t tval;
    logic      ti;

    csr_trap_if trap_bus ();

    // trap events from the pipeline
    assign trap_bus.excp_flush = excp_flush_i;
    assign trap_bus.ertn_flush = ertn_flush_i;
    assign trap_bus.ecode      = ecode_i;
    assign trap_bus.esubcode   = esubcode_i;
    assign trap_bus.era        = era_i;

    csr_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .wr1_we_i   (wr1_we_i),
        .wr1_addr_i (wr1_addr_i),
        .wr1_data_i (wr1_data_i),
        .wr2_we_i   (wr2_we_i),
        .wr2_addr_i (wr2_addr_i),
        .wr2_data_i (wr2_data_i),
        .raddr1_i   (raddr1_i),
        .raddr2_i   (raddr2_i),
        .rdata1_o   (rdata1_o),
        .rdata2_o   (rdata2_o),
        .trap       (trap_bus.epc),
        .crmd_i     (crmd),
        .prmd_i     (prmd),
        .estat_i    (estat),
        .tcfg_i     (tcfg),
        .tval_i     (tval),
        .wr_we_o    (wr_we),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .ectl_lie_o (ectl_lie),
        .eentry_o   (eentry_o),
        .era_o      (era_o)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr_we_i    (wr_we),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .trap       (trap_bus.trap),
        .irq_i      (irq_i),
        .ti_i       (ti),
        .ectl_lie_i (ectl_lie),
        .crmd_o     (crmd),
        .prmd_o     (prmd),
        .estat_o    (estat),
        .plv_o      (plv_o),
        .has_int_o  (has_int_o)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .wr_we_i   (wr_we),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .tcfg_o    (tcfg),
        .tval_o    (tval),
        .ti_o      (ti)
    );

endmodule

// ==== rtl/csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_we_i,
    input  csr_addr_pkg::csr_addr_e wr_addr_i,
    input  csr_addr_pkg::csr_word_t wr_data_i,
    output csr_addr_pkg::csr_word_t tcfg_o,
    output csr_addr_pkg::csr_word_t tval_o,
    output logic                    ti_o
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic                                       en_q;
    logic                                       periodic_q;
    logic [TCFG_INITVAL_HI:TCFG_INITVAL_LO]     initval_q;
    csr_word_t                                  tval_q;
    logic                                       ti_q;

    logic tcfg_wr;
    logic ticlr_wr;
    logic expire;

    assign tcfg_wr  = wr_we_i && (wr_addr_i == CSR_TCFG);
    assign ticlr_wr = wr_we_i && (wr_addr_i == CSR_TICLR) && wr_data_i[TICLR_CLR];
    assign expire   = !tcfg_wr && en_q && (tval_q == '0);

    // countdown and reload
    always_ff @(posedge clk) begin
        if (rst) begin
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
            initval_q  <= '0;
            tval_q     <= '0;
        end else if (tcfg_wr) begin
            en_q       <= wr_data_i[TCFG_EN];
            periodic_q <= wr_data_i[TCFG_PERIODIC];
            initval_q  <= wr_data_i[TCFG_INITVAL_HI:TCFG_INITVAL_LO];
            if (wr_data_i[TCFG_EN]) begin
                tval_q <= {wr_data_i[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b00};
            end
        end else if (expire) begin
            if (periodic_q) begin
                tval_q <= {initval_q, 2'b00};
            end else begin
                en_q <= 1'b0;
            end
        end else if (en_q) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // a new expiry wins over the clear
    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end else if (ticlr_wr) begin
            ti_q <= 1'b0;
        end
    end

    always_comb begin
        tcfg_o = '0;
        tcfg_o[TCFG_EN]                         = en_q;
        tcfg_o[TCFG_PERIODIC]                   = periodic_q;
        tcfg_o[TCFG_INITVAL_HI:TCFG_INITVAL_LO] = initval_q;
    end

    assign tval_o = tval_q;
    assign ti_o   = ti_q;

    a_tval_frozen: assert property (
        @(posedge clk) disable iff (rst) (!en_q && !tcfg_wr) |=> $stable(tval_q)
    ) else $error("csr_timer: TVAL moved while the timer was disabled");

endmodule

// ==== rtl/csr_trap_ctrl.sv ====
`timescale 1ns/10ps

module csr_trap_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_we_i,
    input  csr_addr_pkg::csr_addr_e wr_addr_i,
    input  csr_addr_pkg::csr_word_t wr_data_i,
    csr_trap_if.trap                trap,
    input  csr_field_pkg::hw_irq_t  irq_i,
    input  logic                    ti_i,
    input  csr_field_pkg::int_vec_t ectl_lie_i,
    output csr_addr_pkg::csr_word_t crmd_o,
    output csr_addr_pkg::csr_word_t prmd_o,
    output csr_addr_pkg::csr_word_t estat_o,
    output csr_field_pkg::plv_t     plv_o,
    output logic                    has_int_o
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    plv_t       plv_q;
    logic       ie_q;
    logic       da_q;
    logic       pg_q;
    logic [1:0] datf_q;
    logic [1:0] datm_q;
    plv_t       pplv_q;
    logic       pie_q;
    logic [1:0] swi_q;
    hw_irq_t    hwi_q;
    ecode_t     ecode_q;
    esubcode_t  esub_q;
    int_vec_t   is_vec;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_estat;

    assign wr_crmd  = wr_we_i && (wr_addr_i == CSR_CRMD);
    assign wr_prmd  = wr_we_i && (wr_addr_i == CSR_PRMD);
    assign wr_estat = wr_we_i && (wr_addr_i == CSR_ESTAT);

    // entry drops to plv0 with interrupts off, return restores
    always_ff @(posedge clk) begin
        if (rst) begin
            plv_q  <= CRMD_RESET[CRMD_PLV_HI:CRMD_PLV_LO];
            ie_q   <= CRMD_RESET[CRMD_IE];
            da_q   <= CRMD_RESET[CRMD_DA];
            pg_q   <= CRMD_RESET[CRMD_PG];
            datf_q <= CRMD_RESET[CRMD_DATF_HI:CRMD_DATF_LO];
            datm_q <= CRMD_RESET[CRMD_DATM_HI:CRMD_DATM_LO];
        end else if (trap.excp_flush) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (trap.ertn_flush) begin
            plv_q <= pplv_q;
            ie_q  <= pie_q;
        end else if (wr_crmd) begin
            plv_q  <= wr_data_i[CRMD_PLV_HI:CRMD_PLV_LO];
            ie_q   <= wr_data_i[CRMD_IE];
            da_q   <= wr_data_i[CRMD_DA];
            pg_q   <= wr_data_i[CRMD_PG];
            datf_q <= wr_data_i[CRMD_DATF_HI:CRMD_DATF_LO];
            datm_q <= wr_data_i[CRMD_DATM_HI:CRMD_DATM_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (trap.excp_flush) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (wr_prmd) begin
            pplv_q <= wr_data_i[PRMD_PPLV_HI:PRMD_PPLV_LO];
            pie_q  <= wr_data_i[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            swi_q   <= '0;
            hwi_q   <= '0;
            ecode_q <= '0;
            esub_q  <= '0;
        end else begin
            hwi_q <= irq_i;
            if (trap.excp_flush) begin
                ecode_q <= trap.ecode;
                esub_q  <= trap.esubcode;
            end else if (wr_estat) begin
                swi_q <= wr_data_i[ESTAT_SWI_HI:ESTAT_SWI_LO];
            end
        end
    end

    always_comb begin
        is_vec = '0;
        is_vec[ESTAT_SWI_HI:ESTAT_SWI_LO] = swi_q;
        is_vec[ESTAT_HWI_HI:ESTAT_HWI_LO] = hwi_q;
        is_vec[ESTAT_TI] = ti_i;

        crmd_o = '0;
        crmd_o[CRMD_PLV_HI:CRMD_PLV_LO]   = plv_q;
        crmd_o[CRMD_IE]                   = ie_q;
        crmd_o[CRMD_DA]                   = da_q;
        crmd_o[CRMD_PG]                   = pg_q;
        crmd_o[CRMD_DATF_HI:CRMD_DATF_LO] = datf_q;
        crmd_o[CRMD_DATM_HI:CRMD_DATM_LO] = datm_q;

        prmd_o = '0;
        prmd_o[PRMD_PPLV_HI:PRMD_PPLV_LO] = pplv_q;
        prmd_o[PRMD_PIE]                  = pie_q;

        estat_o = '0;
        estat_o[ESTAT_IS_HI:ESTAT_IS_LO]       = is_vec;
        estat_o[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = ecode_q;
        estat_o[ESTAT_ESUB_HI:ESTAT_ESUB_LO]   = esub_q;
    end

    assign plv_o     = plv_q;
    assign has_int_o = ie_q && ((ectl_lie_i & is_vec) != '0);

    a_entry_return_excl: assert property (
        @(posedge clk) disable iff (rst) !(trap.excp_flush && trap.ertn_flush)
    ) else $error("csr_trap_ctrl: exception entry and return in one cycle");

endmodule

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/10ps

module csr_regfile (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr1_we_i,
    input  csr_addr_pkg::csr_addr_e             wr1_addr_i,
    input  csr_addr_pkg::csr_word_t             wr1_data_i,
    input  logic                                wr2_we_i,
    input  csr_addr_pkg::csr_addr_e             wr2_addr_i,
    input  csr_addr_pkg::csr_word_t             wr2_data_i,
    input  logic [csr_addr_pkg::CSR_ADDR_W-1:0] raddr1_i,
    input  logic [csr_addr_pkg::CSR_ADDR_W-1:0] raddr2_i,
    output csr_addr_pkg::csr_word_t             rdata1_o,
    output csr_addr_pkg::csr_word_t             rdata2_o,
    csr_trap_if.epc                             trap,
    input  csr_addr_pkg::csr_word_t             crmd_i,
    input  csr_addr_pkg::csr_word_t             prmd_i,
    input  csr_addr_pkg::csr_word_t             estat_i,
    input  csr_addr_pkg::csr_word_t             tcfg_i,
    input  csr_addr_pkg::csr_word_t             tval_i,
    output logic                                wr_we_o,
    output csr_addr_pkg::csr_addr_e             wr_addr_o,
    output csr_addr_pkg::csr_word_t             wr_data_o,
    output csr_field_pkg::int_vec_t             ectl_lie_o,
    output csr_addr_pkg::csr_word_t             eentry_o,
    output csr_addr_pkg::csr_word_t             era_o
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    int_vec_t                         ectl_lie_q;
    csr_word_t                        era_q;
    logic [CSR_DATA_W-1:EENTRY_VA_LO] eentry_va_q;
    csr_word_t                        save_q [4];
    csr_word_t                        tid_q;

    logic wr_ectl;
    logic wr_era;
    logic wr_eentry;
    logic wr_save;
    logic wr_tid;

    // pipeline never writes from both ports at once
    assign wr_we_o   = wr1_we_i | wr2_we_i;
    assign wr_addr_o = wr1_we_i ? wr1_addr_i : wr2_addr_i;
    assign wr_data_o = wr1_we_i ? wr1_data_i : wr2_data_i;

    assign wr_ectl   = wr_we_o && (wr_addr_o == CSR_ECTL);
    assign wr_era    = wr_we_o && (wr_addr_o == CSR_ERA);
    assign wr_eentry = wr_we_o && (wr_addr_o == CSR_EENTRY);
    assign wr_save   = wr_we_o && (wr_addr_o inside {CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3});
    assign wr_tid    = wr_we_o && (wr_addr_o == CSR_TID);

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_lie_q  <= '0;
            eentry_va_q <= '0;
            tid_q       <= '0;
        end else begin
            if (wr_ectl) begin
                ectl_lie_q <= wr_data_o[ECTL_LIE_HI:ECTL_LIE_LO];
            end
            if (wr_eentry) begin
                eentry_va_q <= wr_data_o[CSR_DATA_W-1:EENTRY_VA_LO];
            end
            if (wr_tid) begin
                tid_q <= wr_data_o;
            end
        end
    end

    // epc capture beats a software write
    always_ff @(posedge clk) begin
        if (rst) begin
            era_q <= '0;
        end else if (trap.excp_flush) begin
            era_q <= trap.era;
        end else if (wr_era) begin
            era_q <= wr_data_o;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr_save) begin
            save_q[wr_addr_o[1:0]] <= wr_data_o;
        end
    end

    assign ectl_lie_o = ectl_lie_q;
    assign eentry_o   = {eentry_va_q, {EENTRY_VA_LO{1'b0}}};
    assign era_o      = era_q;

    function automatic csr_word_t read_csr(input logic [CSR_ADDR_W-1:0] addr);
        csr_word_t word;
        word = '0;
        case (addr)
            CSR_CRMD:   word = crmd_i;
            CSR_PRMD:   word = prmd_i;
            CSR_ECTL:   word[ECTL_LIE_HI:ECTL_LIE_LO] = ectl_lie_q;
            CSR_ESTAT:  word = estat_i;
            CSR_ERA:    word = era_q;
            CSR_EENTRY: word = eentry_o;
            CSR_SAVE0:  word = save_q[0];
            CSR_SAVE1:  word = save_q[1];
            CSR_SAVE2:  word = save_q[2];
            CSR_SAVE3:  word = save_q[3];
            CSR_TID:    word = tid_q;
            CSR_TCFG:   word = tcfg_i;
            CSR_TVAL:   word = tval_i;
            // write only
            CSR_TICLR:  word = '0;
            default:    word = '0;
        endcase
        return word;
    endfunction

    always_comb begin
        rdata1_o = read_csr(raddr1_i);
        rdata2_o = read_csr(raddr2_i);
    end

    a_single_writer: assert property (
        @(posedge clk) disable iff (rst) !(wr1_we_i && wr2_we_i)
    ) else $error("csr_regfile: both write ports strobed in one cycle");

endmodule

// ==== rtl/csr_trap_if.sv ====
`timescale 1ns/10ps

interface csr_trap_if;
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic      excp_flush;
    logic      ertn_flush;
    ecode_t    ecode;
    esubcode_t esubcode;
    csr_word_t era;

    modport src (
        output excp_flush,
        output ertn_flush,
        output ecode,
        output esubcode,
        output era
    );

    modport trap (
        input excp_flush,
        input ertn_flush,
        input ecode,
        input esubcode,
        input era
    );

    // only the epc capture needs these
    modport epc (
        input excp_flush,
        input era
    );

endinterface

// ==== rtl/csr_field_pkg.sv ====
package csr_field_pkg;

    localparam int PLV_W      = 2;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int IS_W       = 13;
    localparam int HWI_W      = 8;

    typedef logic [PLV_W-1:0]      plv_t;
    typedef logic [ECODE_W-1:0]    ecode_t;
    typedef logic [ESUBCODE_W-1:0] esubcode_t;
    typedef logic [IS_W-1:0]       int_vec_t;
    typedef logic [HWI_W-1:0]      hw_irq_t;

    // crmd
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    // direct address mode out of reset
    localparam csr_addr_pkg::csr_word_t CRMD_RESET = 32'h0000_0008;

    // prmd
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    // ectl
    localparam int ECTL_LIE_LO = 0;
    localparam int ECTL_LIE_HI = 12;

    // estat
    localparam int ESTAT_IS_LO    = 0;
    localparam int ESTAT_IS_HI    = 12;
    localparam int ESTAT_SWI_LO   = 0;
    localparam int ESTAT_SWI_HI   = 1;
    localparam int ESTAT_HWI_LO   = 2;
    localparam int ESTAT_HWI_HI   = 9;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ESUB_LO  = 22;
    localparam int ESTAT_ESUB_HI  = 30;

    // timer
    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_HI = 31;
    localparam int TICLR_CLR       = 0;

    // eentry is 64 byte aligned
    localparam int EENTRY_VA_LO = 6;

endpackage

// ==== rtl/csr_addr_pkg.sv ====
package csr_addr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_DATA_W-1:0] csr_word_t;

    // implemented CSR numbers
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

endpackage
